// File: hdl/dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////////////////////////
    // Fixed widths
    //////////////////////////////////////////////////

    localparam int ADDR_W    = 32;
    localparam int WORD_W    = 32;
    // Four words per line
    localparam int LINE_W    = 128;
    localparam int OOO_TAG_W = 10;
    localparam int ROB_W     = 10;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Pipeline operation
    typedef enum logic [1:0] {
        OP_NONE,
        OP_LD,
        OP_ST
    } mem_op_e;

    // Access size from the reservation stations
    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } acc_size_e;

endpackage

// File: hdl/dc_req_if.sv
`timescale 1ns/1ps

interface dc_req_if;
    import dcache_pkg::*;

    logic                 valid;
    logic                 ready;
    mem_op_e              op;
    logic [ADDR_W-1:0]    addr;
    logic [WORD_W-1:0]    data;
    acc_size_e            size;
    logic                 sext;
    logic [OOO_TAG_W-1:0] ooo_tag;
    logic [ROB_W-1:0]     rob;

    modport src (output valid, op, addr, data, size, sext, ooo_tag, rob, input ready);
    modport dst (input valid, op, addr, data, size, sext, ooo_tag, rob, output ready);

    // Receiver always accepts
    modport pass_src (output valid, op, addr, data, size, sext, ooo_tag, rob);
    modport pass_dst (input valid, op, addr, data, size, sext, ooo_tag, rob);

endinterface

// File: hdl/dc_in_queue.sv
`timescale 1ns/1ps

module dc_in_queue #(
    parameter int Q_DEPTH = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           flush_i,
    input  logic                           alloc_i,
    input  dcache_pkg::mem_op_e            op_i,
    input  logic [dcache_pkg::ADDR_W-1:0]    addr_i,
    input  logic [dcache_pkg::WORD_W-1:0]    data_i,
    input  dcache_pkg::acc_size_e          size_i,
    input  logic                           sext_i,
    input  logic [dcache_pkg::OOO_TAG_W-1:0] ooo_tag_i,
    input  logic [dcache_pkg::ROB_W-1:0]     rob_i,
    output logic                           full_o,
    dc_req_if.src                          q2a
);
    import dcache_pkg::*;

    localparam int PTR_W = (Q_DEPTH > 1) ? $clog2(Q_DEPTH) : 1;
    localparam int CNT_W = $clog2(Q_DEPTH + 1);

    mem_op_e              op_q      [Q_DEPTH];
    logic [ADDR_W-1:0]    addr_q    [Q_DEPTH];
    logic [WORD_W-1:0]    data_q    [Q_DEPTH];
    acc_size_e            size_q    [Q_DEPTH];
    logic                 sext_q    [Q_DEPTH];
    logic [OOO_TAG_W-1:0] ooo_tag_q [Q_DEPTH];
    logic [ROB_W-1:0]     rob_q     [Q_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(Q_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o = (count_q == CNT_W'(Q_DEPTH));
    assign push   = alloc_i && !full_o;
    assign pop    = q2a.valid && q2a.ready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Resteer drops everything queued, including this cycle's alloc
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            if (push && !pop)
                count_q <= count_q + 1'b1;
            else if (!push && pop)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            op_q[wr_ptr_q]      <= op_i;
            addr_q[wr_ptr_q]    <= addr_i;
            data_q[wr_ptr_q]    <= data_i;
            size_q[wr_ptr_q]    <= size_i;
            sext_q[wr_ptr_q]    <= sext_i;
            ooo_tag_q[wr_ptr_q] <= ooo_tag_i;
            rob_q[wr_ptr_q]     <= rob_i;
        end
    end

    // Head entry
    assign q2a.valid   = (count_q != '0);
    assign q2a.op      = op_q[rd_ptr_q];
    assign q2a.addr    = addr_q[rd_ptr_q];
    assign q2a.data    = data_q[rd_ptr_q];
    assign q2a.size    = size_q[rd_ptr_q];
    assign q2a.sext    = sext_q[rd_ptr_q];
    assign q2a.ooo_tag = ooo_tag_q[rd_ptr_q];
    assign q2a.rob     = rob_q[rd_ptr_q];

endmodule

// File: hdl/dc_align.sv
`timescale 1ns/1ps

module dc_align (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    dc_req_if.dst                           q2a,
    dc_req_if.src                           a2x,
    output logic [dcache_pkg::WORD_W/8-1:0] byte_en_o
);
    import dcache_pkg::*;

    logic [WORD_W/8-1:0] lane_be;
    logic [WORD_W-1:0]   lane_data;
    logic                take;

    // Empty or draining this cycle
    assign q2a.ready = !a2x.valid || a2x.ready;
    assign take      = q2a.valid && q2a.ready;

    // Byte lanes from size and low address bits
    always_comb begin
        case (q2a.size)
            SZ_BYTE: begin
                lane_be   = 4'b0001 << q2a.addr[1:0];
                lane_data = {4{q2a.data[7:0]}};
            end
            SZ_HALF: begin
                lane_be   = 4'b0011 << {q2a.addr[1], 1'b0};
                lane_data = {2{q2a.data[15:0]}};
            end
            default: begin
                lane_be   = 4'b1111;
                lane_data = q2a.data;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            a2x.valid <= 1'b0;
        end else if (flush_i) begin
            a2x.valid <= 1'b0;
        end else if (q2a.ready) begin
            a2x.valid <= q2a.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            a2x.op      <= q2a.op;
            a2x.addr    <= q2a.addr;
            a2x.data    <= lane_data;
            a2x.size    <= q2a.size;
            a2x.sext    <= q2a.sext;
            a2x.ooo_tag <= q2a.ooo_tag;
            a2x.rob     <= q2a.rob;
            byte_en_o   <= lane_be;
        end
    end

endmodule

// File: hdl/dc_access.sv
`timescale 1ns/1ps

module dc_access #(
    parameter int IDX_CNT = 512
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    dc_req_if.dst                           a2x,
    input  logic [dcache_pkg::WORD_W/8-1:0] byte_en_i,
    input  logic                            fill_valid_i,
    input  logic [dcache_pkg::LINE_W-1:0]   fill_data_i,
    output logic                            miss_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0]   miss_addr_o,
    dc_req_if.pass_src                      a2r
);
    import dcache_pkg::*;

    localparam int OFF_W   = $clog2(LINE_W / 8);
    localparam int WSEL_LO = $clog2(WORD_W / 8);
    localparam int WSEL_W  = $clog2(LINE_W / WORD_W);
    localparam int IDX_W   = $clog2(IDX_CNT);
    localparam int LTAG_W  = ADDR_W - IDX_W - OFF_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MISS,
        ST_REPLAY
    } state_e;

    state_e state_q;

    // Arrays
    logic [IDX_CNT-1:0] line_vld_q;
    logic [LTAG_W-1:0]  ltag_q [IDX_CNT];
    logic [LINE_W-1:0]  line_q [IDX_CNT];

    // Request held across a miss
    mem_op_e              hold_op;
    logic [ADDR_W-1:0]    hold_addr;
    logic [WORD_W-1:0]    hold_data;
    acc_size_e            hold_size;
    logic                 hold_sext;
    logic [OOO_TAG_W-1:0] hold_ooo_tag;
    logic [ROB_W-1:0]     hold_rob;
    logic [WORD_W/8-1:0]  hold_be;

    mem_op_e              cur_op;
    logic [ADDR_W-1:0]    cur_addr;
    logic [WORD_W-1:0]    cur_data;
    acc_size_e            cur_size;
    logic                 cur_sext;
    logic [OOO_TAG_W-1:0] cur_ooo_tag;
    logic [ROB_W-1:0]     cur_rob;
    logic [WORD_W/8-1:0]  cur_be;

    logic [IDX_W-1:0]  cur_idx;
    logic [LTAG_W-1:0] cur_ltag;
    logic [WSEL_W-1:0] cur_wsel;
    logic [WORD_W-1:0] cur_word;
    logic [WORD_W-1:0] merged_word;
    logic              hit;
    logic              accept;
    logic              do_access;
    logic              fill_we;

    assign a2x.ready = (state_q == ST_IDLE);
    assign accept    = a2x.valid && a2x.ready;

    // Incoming request when idle, held one otherwise
    always_comb begin
        if (state_q == ST_IDLE) begin
            cur_op      = a2x.op;
            cur_addr    = a2x.addr;
            cur_data    = a2x.data;
            cur_size    = a2x.size;
            cur_sext    = a2x.sext;
            cur_ooo_tag = a2x.ooo_tag;
            cur_rob     = a2x.rob;
            cur_be      = byte_en_i;
        end else begin
            cur_op      = hold_op;
            cur_addr    = hold_addr;
            cur_data    = hold_data;
            cur_size    = hold_size;
            cur_sext    = hold_sext;
            cur_ooo_tag = hold_ooo_tag;
            cur_rob     = hold_rob;
            cur_be      = hold_be;
        end
    end

    assign cur_idx  = cur_addr[OFF_W +: IDX_W];
    assign cur_ltag = cur_addr[ADDR_W-1 -: LTAG_W];
    assign cur_wsel = cur_addr[WSEL_LO +: WSEL_W];
    assign cur_word = line_q[cur_idx][cur_wsel*WORD_W +: WORD_W];
    assign hit      = line_vld_q[cur_idx] && (ltag_q[cur_idx] == cur_ltag);

    assign do_access = (accept && hit) || (state_q == ST_REPLAY);
    assign fill_we   = (state_q == ST_MISS) && fill_valid_i;

    always_comb begin
        merged_word = cur_word;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (cur_be[b])
                merged_word[b*8 +: 8] = cur_data[b*8 +: 8];
        end
    end

    //////////////////////////////////////////////////
    // Miss FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:   if (accept && !hit) state_q <= ST_MISS;
                ST_MISS:   if (fill_valid_i) state_q <= ST_REPLAY;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    assign miss_valid_o = (state_q == ST_MISS);
    assign miss_addr_o  = {hold_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_op      <= a2x.op;
            hold_addr    <= a2x.addr;
            hold_data    <= a2x.data;
            hold_size    <= a2x.size;
            hold_sext    <= a2x.sext;
            hold_ooo_tag <= a2x.ooo_tag;
            hold_rob     <= a2x.rob;
            hold_be      <= byte_en_i;
        end
    end

    //////////////////////////////////////////////////
    // Array update
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            line_vld_q <= '0;
        else if (fill_we)
            line_vld_q[cur_idx] <= 1'b1;
    end

    always_ff @(posedge clk_i) begin
        if (fill_we) begin
            line_q[cur_idx] <= fill_data_i;
            ltag_q[cur_idx] <= cur_ltag;
        end else if (do_access && cur_op == OP_ST) begin
            // Write-allocate store merge
            line_q[cur_idx][cur_wsel*WORD_W +: WORD_W] <= merged_word;
        end
    end

    // Result to the response stage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            a2r.valid <= 1'b0;
        else
            a2r.valid <= do_access;
    end

    always_ff @(posedge clk_i) begin
        if (do_access) begin
            a2r.op      <= cur_op;
            a2r.addr    <= cur_addr;
            a2r.data    <= cur_word;
            a2r.size    <= cur_size;
            a2r.sext    <= cur_sext;
            a2r.ooo_tag <= cur_ooo_tag;
            a2r.rob     <= cur_rob;
        end
    end

endmodule

// File: hdl/dc_respond.sv
`timescale 1ns/1ps

module dc_respond (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    dc_req_if.pass_dst                       a2r,
    output logic                             valid_o,
    output logic [dcache_pkg::ADDR_W-1:0]    addr_o,
    output logic [dcache_pkg::WORD_W-1:0]    data_o,
    output logic                             is_st_o,
    output logic [dcache_pkg::OOO_TAG_W-1:0] tag_o,
    output logic [dcache_pkg::ROB_W-1:0]     rob_o
);
    import dcache_pkg::*;

    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic [WORD_W-1:0] ext_word;

    // Lane select by byte address
    assign byte_sel = a2r.data[a2r.addr[1:0]*8 +: 8];
    assign half_sel = a2r.data[a2r.addr[1]*16 +: 16];

    always_comb begin
        case (a2r.size)
            SZ_BYTE: ext_word = {{(WORD_W-8){a2r.sext & byte_sel[7]}}, byte_sel};
            SZ_HALF: ext_word = {{(WORD_W-16){a2r.sext & half_sel[15]}}, half_sel};
            default: ext_word = a2r.data;
        endcase
        // Stores return no data
        if (a2r.op == OP_ST)
            ext_word = '0;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else
            valid_o <= a2r.valid;
    end

    always_ff @(posedge clk_i) begin
        if (a2r.valid) begin
            addr_o  <= a2r.addr;
            data_o  <= ext_word;
            is_st_o <= (a2r.op == OP_ST);
            tag_o   <= a2r.ooo_tag;
            rob_o   <= a2r.rob;
        end
    end

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int Q_DEPTH = 8,
    parameter int IDX_CNT = 512
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    // Reservation stations
    input  logic                             alloc_i,
    input  logic [dcache_pkg::ADDR_W-1:0]    addr_i,
    input  logic [dcache_pkg::WORD_W-1:0]    data_i,
    input  dcache_pkg::acc_size_e            size_i,
    input  logic                             is_st_i,
    input  logic                             sext_i,
    input  logic [dcache_pkg::OOO_TAG_W-1:0] ooo_tag_i,
    input  logic [dcache_pkg::ROB_W-1:0]     rob_i,
    output logic                             stall_o,

    // ROB
    input  logic                             rob_resteer_i,
    output logic                             valid_o,
    output logic [dcache_pkg::ADDR_W-1:0]    addr_o,
    output logic [dcache_pkg::WORD_W-1:0]    data_o,
    output logic                             is_st_o,
    output logic [dcache_pkg::OOO_TAG_W-1:0] tag_o,
    output logic [dcache_pkg::ROB_W-1:0]     rob_o,

    // Memory side
    input  logic                             fill_valid_i,
    input  logic [dcache_pkg::LINE_W-1:0]    fill_data_i,
    output logic                             miss_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0]    miss_addr_o
);
    import dcache_pkg::*;

    dc_req_if q2a ();
    dc_req_if a2x ();
    dc_req_if a2r ();

    logic [WORD_W/8-1:0] byte_en;

    dc_in_queue #(.Q_DEPTH(Q_DEPTH)) u_in_queue (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (rob_resteer_i),
        .alloc_i   (alloc_i),
        .op_i      (is_st_i ? OP_ST : OP_LD),
        .addr_i    (addr_i),
        .data_i    (data_i),
        .size_i    (size_i),
        .sext_i    (sext_i),
        .ooo_tag_i (ooo_tag_i),
        .rob_i     (rob_i),
        .full_o    (stall_o),
        .q2a       (q2a.src)
    );

    dc_align u_align (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (rob_resteer_i),
        .q2a       (q2a.dst),
        .a2x       (a2x.src),
        .byte_en_o (byte_en)
    );

    dc_access #(.IDX_CNT(IDX_CNT)) u_access (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .a2x          (a2x.dst),
        .byte_en_i    (byte_en),
        .fill_valid_i (fill_valid_i),
        .fill_data_i  (fill_data_i),
        .miss_valid_o (miss_valid_o),
        .miss_addr_o  (miss_addr_o),
        .a2r          (a2r.pass_src)
    );

    dc_respond u_respond (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .a2r     (a2r.pass_dst),
        .valid_o (valid_o),
        .addr_o  (addr_o),
        .data_o  (data_o),
        .is_st_o (is_st_o),
        .tag_o   (tag_o),
        .rob_o   (rob_o)
    );

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: sim/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int Q_DEPTH   = 8;
    localparam int IDX_CNT   = 512;
    localparam int DRIVE_DLY = 10;
    localparam int WAIT_MAX  = 200;
    localparam int DRAIN_MAX = 3000;
    localparam int HOLD_MAX  = 1000;
    localparam int MEM_WORDS = 4096;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        acc_size_e   size;
        logic        is_st;
        logic [9:0]  tag;
        logic [9:0]  rob;
        logic [31:0] exp_data;
    } resp_t;

    logic         clk;
    logic         rst_n;
    logic         req_alloc;
    logic [31:0]  req_addr;
    logic [31:0]  req_data;
    acc_size_e    req_size;
    logic         req_is_st;
    logic         req_sext;
    logic [9:0]   req_tag;
    logic [9:0]   req_rob;
    logic         stall;
    logic         resteer;
    logic         resp_valid;
    logic [31:0]  resp_addr;
    logic [31:0]  resp_data;
    logic         resp_is_st;
    logic [9:0]   resp_tag;
    logic [9:0]   resp_rob;
    logic         fill_valid;
    logic [127:0] fill_data;
    logic         miss_valid;
    logic [31:0]  miss_addr;

    // Reference memory in request order, memory model in completion order
    logic [31:0] ref_mem   [MEM_WORDS];
    logic [31:0] mem_model [MEM_WORDS];
    resp_t       exp_q     [$];

    logic [15:0] lfsr_state = 16'd20518;
    logic        hold_fill  = 1'b0;
    string       cur_test   = "reset";
    int          seq        = 0;
    int          err_count  = 0;
    int          test_err0  = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          resp_count = 0;
    int          miss_count = 0;

    tb_clk_gen #(.PERIOD(100), .RST_CYCLES(2)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dcache_top #(.Q_DEPTH(Q_DEPTH), .IDX_CNT(IDX_CNT)) u_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .alloc_i       (req_alloc),
        .addr_i        (req_addr),
        .data_i        (req_data),
        .size_i        (req_size),
        .is_st_i       (req_is_st),
        .sext_i        (req_sext),
        .ooo_tag_i     (req_tag),
        .rob_i         (req_rob),
        .stall_o       (stall),
        .rob_resteer_i (resteer),
        .valid_o       (resp_valid),
        .addr_o        (resp_addr),
        .data_o        (resp_data),
        .is_st_o       (resp_is_st),
        .tag_o         (resp_tag),
        .rob_o         (resp_rob),
        .fill_valid_i  (fill_valid),
        .fill_data_i   (fill_data),
        .miss_valid_o  (miss_valid),
        .miss_addr_o   (miss_addr)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (b ? 16'hb400 : 16'h0000);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] init_word(input logic [31:0] waddr);
        return (waddr * 32'h9e37_79b1) ^ 32'h5eed_c0de;
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] addr,
                                                input logic [31:0] data, input acc_size_e size);
        logic [31:0] w;
        w = old;
        case (size)
            SZ_BYTE: w[addr[1:0]*8 +: 8] = data[7:0];
            SZ_HALF: w[addr[1]*16 +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    // Expected response data; stores update the reference memory
    function automatic logic [31:0] ref_access(input logic [31:0] addr, input logic [31:0] data,
                                               input acc_size_e size, input logic is_st,
                                               input logic sext);
        logic [31:0] w;
        logic [31:0] res;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[addr[13:2]];
        b = w[addr[1:0]*8 +: 8];
        h = w[addr[1]*16 +: 16];
        case (size)
            SZ_BYTE: res = sext ? {{24{b[7]}}, b} : {24'h0, b};
            SZ_HALF: res = sext ? {{16{h[15]}}, h} : {16'h0, h};
            default: res = w;
        endcase
        if (is_st) begin
            ref_mem[addr[13:2]] = merge_store(w, addr, data, size);
            res = 32'h0;
        end
        return res;
    endfunction

    task automatic show_mismatch(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        $display("** Error %s %s: expected %h, actual %h", cur_test, field, exp_v, act_v);
        err_count++;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = err_count;
    endtask

    task automatic finish_test();
        $display("%-16s finished with %0d failures", cur_test, err_count - test_err0);
        test_count++;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic issue_req(input logic [31:0] addr, input logic [31:0] data,
                             input acc_size_e size, input logic is_st, input logic sext,
                             input logic expect_resp);
        resp_t e;
        int    n;
        n = 0;
        while (stall && n < WAIT_MAX) begin
            step_cycle();
            n++;
        end
        if (stall) begin
            $display("Queue stayed full in %s, request to %h not sent", cur_test, addr);
            err_count++;
            return;
        end
        req_alloc = 1'b1;
        req_addr  = addr;
        req_data  = data;
        req_size  = size;
        req_is_st = is_st;
        req_sext  = sext;
        req_tag   = seq[9:0];
        req_rob   = seq[9:0] ^ 10'h2a5;
        if (expect_resp) begin
            e.addr     = addr;
            e.wdata    = data;
            e.size     = size;
            e.is_st    = is_st;
            e.tag      = req_tag;
            e.rob      = req_rob;
            e.exp_data = ref_access(addr, data, size, is_st, sext);
            exp_q.push_back(e);
        end
        step_cycle();
        req_alloc = 1'b0;
        seq++;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_MAX) begin
            step_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived in %s", exp_q.size(), cur_test);
            err_count++;
            exp_q.delete();
        end
    endtask

    task automatic wait_miss();
        int n;
        n = 0;
        while (!miss_valid && n < WAIT_MAX) begin
            step_cycle();
            n++;
        end
        if (!miss_valid) begin
            $display("No line request seen in %s", cur_test);
            err_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // Memory model and response checker
    //////////////////////////////////////////////////

    initial begin : mem_proc
        int n;
        int delay;
        fill_valid = 1'b0;
        fill_data  = '0;
        forever begin
            step_cycle();
            if (miss_valid) begin
                miss_count++;
                n = 0;
                while (hold_fill && n < HOLD_MAX) begin
                    step_cycle();
                    n++;
                end
                if (hold_fill) begin
                    $display("Fill held too long in %s", cur_test);
                    err_count++;
                end
                // Two to five cycles
                delay = 2 + (miss_count % 4);
                repeat (delay) step_cycle();
                for (int i = 0; i < 4; i++)
                    fill_data[i*32 +: 32] = mem_model[{miss_addr[13:4], i[1:0]}];
                fill_valid = 1'b1;
                step_cycle();
                fill_valid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin : compare_proc
        resp_t e;
        if (rst_n && resp_valid) begin
            resp_count++;
            check_count++;
            if (exp_q.size() == 0) begin
                $display("Unexpected response in %s with tag %h", cur_test, resp_tag);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                if (resp_data !== e.exp_data)
                    show_mismatch("data", e.exp_data, resp_data);
                if (resp_addr !== e.addr)
                    show_mismatch("addr", e.addr, resp_addr);
                if (resp_is_st !== e.is_st)
                    show_mismatch("is_st", 32'(e.is_st), 32'(resp_is_st));
                if (resp_tag !== e.tag)
                    show_mismatch("tag", 32'(e.tag), 32'(resp_tag));
                if (resp_rob !== e.rob)
                    show_mismatch("rob", 32'(e.rob), 32'(resp_rob));
                if (e.is_st)
                    mem_model[e.addr[13:2]] = merge_store(mem_model[e.addr[13:2]], e.addr,
                                                          e.wdata, e.size);
            end
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin : main_proc
        logic [31:0] r;
        logic [31:0] d;
        logic [1:0]  boff;
        acc_size_e   sz;
        int          n;
        int          lat;
        int          issued;
        int          base_resp;
        int          base_miss;

        req_alloc = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        req_size  = SZ_WORD;
        req_is_st = 1'b0;
        req_sext  = 1'b0;
        req_tag   = '0;
        req_rob   = '0;
        resteer   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i]   = init_word(i);
            mem_model[i] = ref_mem[i];
        end

        n = 0;
        while (!rst_n && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        step_cycle();

        start_test("load_miss_hit");
        issue_req(32'h0000_0104, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        wait_miss();
        check_count++;
        if (miss_addr !== 32'h0000_0100)
            show_mismatch("miss_addr", 32'h0000_0100, miss_addr);
        wait_drain();
        base_miss = miss_count;
        issue_req(32'h0000_0108, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        lat = 1;
        while (!resp_valid && lat < WAIT_MAX) begin
            step_cycle();
            lat++;
        end
        check_count++;
        if (lat != 4)
            show_mismatch("hit latency", 32'd4, 32'(lat));
        wait_drain();
        if (miss_count != base_miss)
            show_mismatch("miss count", 32'(base_miss), 32'(miss_count));
        finish_test();

        start_test("store_merge");
        issue_req(32'h0000_0101, 32'h0000_00ab, SZ_BYTE, 1'b1, 1'b0, 1'b1);
        issue_req(32'h0000_0102, 32'h0000_beef, SZ_HALF, 1'b1, 1'b0, 1'b1);
        issue_req(32'h0000_0108, 32'h1234_5678, SZ_WORD, 1'b1, 1'b0, 1'b1);
        issue_req(32'h0000_0303, 32'h0000_005c, SZ_BYTE, 1'b1, 1'b0, 1'b1);
        issue_req(32'h0000_0306, 32'h0000_a1b2, SZ_HALF, 1'b1, 1'b0, 1'b1);
        issue_req(32'h0000_0508, 32'hcafe_f00d, SZ_WORD, 1'b1, 1'b0, 1'b1);
        issue_req(32'h0000_0100, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        issue_req(32'h0000_0108, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        issue_req(32'h0000_0300, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        issue_req(32'h0000_0304, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        issue_req(32'h0000_0508, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        wait_drain();
        finish_test();

        start_test("load_extend");
        // Lanes 0xf0, 0x7f, 0x01, 0x80
        issue_req(32'h0000_0400, 32'h8001_7ff0, SZ_WORD, 1'b1, 1'b0, 1'b1);
        for (int k = 0; k < 4; k++) begin
            issue_req(32'h0000_0400 + k, '0, SZ_BYTE, 1'b0, 1'b0, 1'b1);
            issue_req(32'h0000_0400 + k, '0, SZ_BYTE, 1'b0, 1'b1, 1'b1);
        end
        for (int k = 0; k < 4; k += 2) begin
            issue_req(32'h0000_0400 + k, '0, SZ_HALF, 1'b0, 1'b0, 1'b1);
            issue_req(32'h0000_0400 + k, '0, SZ_HALF, 1'b0, 1'b1, 1'b1);
        end
        wait_drain();
        finish_test();

        start_test("random_stream");
        for (int k = 0; k < 200; k++) begin
            // Eight indexes with two tags each
            r = rand_bits(12);
            d = rand_bits(32);
            if (r[9:8] == 2'd0) begin
                sz   = SZ_BYTE;
                boff = r[7:6];
            end else if (r[9:8] == 2'd1) begin
                sz   = SZ_HALF;
                boff = {r[7], 1'b0};
            end else begin
                sz   = SZ_WORD;
                boff = 2'b00;
            end
            issue_req({18'h0, r[0], 6'h0, r[3:1], r[5:4], boff}, d, sz, r[10], r[11], 1'b1);
        end
        wait_drain();
        finish_test();

        start_test("stall_on_miss");
        hold_fill = 1'b1;
        base_resp = resp_count;
        issued    = 0;
        while (!stall && issued < 16) begin
            issue_req(32'h0000_1400 + 4 * (issued % 4), '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
            issued++;
        end
        check_count++;
        if (!stall) begin
            $display("stall_o never rose in %s", cur_test);
            err_count++;
        end
        if (issued != Q_DEPTH + 2)
            show_mismatch("accepted before stall", 32'(Q_DEPTH + 2), 32'(issued));
        repeat (20) step_cycle();
        if (resp_count != base_resp)
            show_mismatch("responses while held", 32'(base_resp), 32'(resp_count));
        hold_fill = 1'b0;
        wait_drain();
        if (resp_count - base_resp != issued)
            show_mismatch("responses", 32'(issued), 32'(resp_count - base_resp));
        finish_test();

        start_test("resteer");
        hold_fill = 1'b1;
        base_resp = resp_count;
        issue_req(32'h0000_1800, '0, SZ_WORD, 1'b0, 1'b0, 1'b1);
        issue_req(32'h0000_1804, '0, SZ_WORD, 1'b0, 1'b0, 1'b0);
        issue_req(32'h0000_1808, '0, SZ_BYTE, 1'b0, 1'b1, 1'b0);
        issue_req(32'h0000_0104, '0, SZ_WORD, 1'b0, 1'b0, 1'b0);
        wait_miss();
        resteer = 1'b1;
        step_cycle();
        resteer   = 1'b0;
        hold_fill = 1'b0;
        wait_drain();
        repeat (20) step_cycle();
        check_count++;
        if (resp_count - base_resp != 1)
            show_mismatch("responses", 32'd1, 32'(resp_count - base_resp));
        finish_test();

        $display("%0d tests, %0d checks, %0d failures", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim.f
hdl/dcache_pkg.sv
hdl/dc_req_if.sv
hdl/dc_in_queue.sv
hdl/dc_align.sv
hdl/dc_access.sv
hdl/dc_respond.sv
hdl/dcache_top.sv
sim/tb_clk_gen.sv
sim/dcache_tb.sv
